/* include/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// -------------------- Widths
`define XLEN       32
`define REG_ADDR_W 4    // RV32E, 16 registers
`define CSR_IDX_W  3
`define ALU_OP_W   4
`define LD_KIND_W  3
`define ST_KIND_W  2

// -------------------- Opcodes
`define OP_IMM    7'b0010011
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_SYSTEM 7'b1110011
`define OP_REG    7'b0110011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_FENCE  7'b0001111

// -------------------- Funct3 codes
`define F3_PRIV  3'b000
`define F3_CSRRW 3'b001
`define F3_CSRRS 3'b010
`define F3_SR    3'b101  // SRL/SRA, funct7[5] picks one

// -------------------- ALU codes, R-type ops use {funct7[5], funct3}
`define ALU_ADD 4'b0000
`define ALU_OR  4'b0110
`define ALU_EQ  4'b1001
`define ALU_NEQ 4'b1010
`define ALU_LT  4'b1011
`define ALU_GE  4'b1100
`define ALU_LTU 4'b1110
`define ALU_GEU 4'b1111

// -------------------- Load and store kinds
`define LD_NONE 3'd0
`define LD_B    3'd1
`define LD_H    3'd2
`define LD_W    3'd3
`define LD_BU   3'd4
`define LD_HU   3'd5
`define ST_NONE 2'd0
`define ST_B    2'd1
`define ST_H    2'd2
`define ST_W    2'd3

// -------------------- System immediates
`define IMM_ECALL  12'h000
`define IMM_EBREAK 12'h001
`define IMM_MRET   12'h302

// -------------------- CSR numbers and compressed indices
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12

`define CSR_NONE      3'd0
`define CSR_MSTATUS   3'd1
`define CSR_MTVEC     3'd2
`define CSR_MEPC      3'd3
`define CSR_MCAUSE    3'd4
`define CSR_MVENDORID 3'd5
`define CSR_MARCHID   3'd6

`define MVENDORID_VAL 32'h5256_3345
`define MARCHID_VAL   32'h0000_0019

`endif

/* verilog/core_pkg.sv */
`include "rv_params.svh"

package core_pkg;

	// -------------------- Basic words
	typedef logic [`XLEN-1:0]       xlen_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`CSR_IDX_W-1:0]  csr_idx_t;   // Zero means no CSR
	typedef logic [`ALU_OP_W-1:0]   alu_op_t;
	typedef logic [`LD_KIND_W-1:0]  mem_rd_t;
	typedef logic [`ST_KIND_W-1:0]  mem_wr_t;

	// -------------------- Pipeline records
	typedef struct packed {
		reg_addr_t rd;
		logic      rd_we;
		csr_idx_t  csr;
		logic      csr_we;
	} pipe_dest_t;   // Destination of one in-flight stage

	typedef struct packed {
		xlen_t data;
		logic  valid;   // Data is final
	} fwd_t;

	typedef struct packed {
		reg_addr_t rd;
		logic      rd_we;
		xlen_t     rd_data;
		csr_idx_t  csr;
		logic      csr_we;
		xlen_t     csr_data;
	} wb_write_t;

	typedef struct packed {
		xlen_t     pc;
		xlen_t     src1;
		xlen_t     src2;
		xlen_t     store_data;
		xlen_t     imm;
		reg_addr_t rd;
		alu_op_t   alu_op;
		logic      reg_we;
		mem_rd_t   mem_rd;
		mem_wr_t   mem_wr;
		csr_idx_t  csr_rd;
		csr_idx_t  csr_wr;
		logic      csr_we;
		logic      is_jump;
		logic      is_jalr;
		logic      ecall;
		logic      ebreak;
		logic      mret;
		logic      fence_i;
	} dec_bundle_t;   // To EXU

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic      use_rs1;
		logic      use_rs2;
		csr_idx_t  csr_rd;
		logic      use_csr;
	} dec_ctrl_t;   // Decoder to hazard unit

endpackage

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module inst_decoder import core_pkg::*; (
	input  xlen_t       inst,
	input  xlen_t       pc,
	input  xlen_t       rs1_val,
	input  xlen_t       rs2_val,
	input  xlen_t       csr_val,
	output dec_ctrl_t   ctrl,
	output dec_bundle_t bundle
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        funct7_5;
	logic [11:0] sys_imm;
	xlen_t       imm_i, imm_s, imm_b, imm_u, imm_j;
	csr_idx_t    csr_map;
	logic        is_priv;

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7_5 = inst[30];
	assign sys_imm  = inst[31:20];
	assign is_priv  = (opcode == `OP_SYSTEM) && (funct3 == `F3_PRIV);

	// -------------------- Immediates
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (sys_imm)   // CSR number to compressed index
			`CSR_ADDR_MSTATUS:   csr_map = `CSR_MSTATUS;
			`CSR_ADDR_MTVEC:     csr_map = `CSR_MTVEC;
			`CSR_ADDR_MEPC:      csr_map = `CSR_MEPC;
			`CSR_ADDR_MCAUSE:    csr_map = `CSR_MCAUSE;
			`CSR_ADDR_MVENDORID: csr_map = `CSR_MVENDORID;
			`CSR_ADDR_MARCHID:   csr_map = `CSR_MARCHID;
			default:             csr_map = `CSR_NONE;
		endcase
	end

	// -------------------- Control bundle
	always_comb begin
		bundle            = '0;
		bundle.pc         = pc;
		bundle.rd         = inst[10:7];
		bundle.src1       = rs1_val;
		bundle.src2       = rs2_val;
		bundle.store_data = rs2_val;
		bundle.alu_op     = `ALU_ADD;
		bundle.mem_rd     = `LD_NONE;
		bundle.mem_wr     = `ST_NONE;
		ctrl              = '0;
		ctrl.rs1          = inst[18:15];   // RV32E uses the low 4 bits
		ctrl.rs2          = inst[23:20];

		if (is_priv && sys_imm == `IMM_ECALL) begin
			bundle.csr_rd = `CSR_MTVEC;   // Jump target
			bundle.csr_wr = `CSR_MEPC;
		end else if (is_priv && sys_imm == `IMM_MRET) begin
			bundle.csr_rd = `CSR_MEPC;
			bundle.csr_wr = `CSR_NONE;
		end else if (opcode == `OP_SYSTEM) begin
			bundle.csr_rd = csr_map;
			bundle.csr_wr = csr_map;
		end

		case (opcode)
			`OP_IMM: begin
				bundle.imm    = imm_i;
				bundle.src2   = imm_i;
				bundle.reg_we = 1'b1;
				bundle.alu_op = {(funct3 == `F3_SR) ? funct7_5 : 1'b0, funct3};
				ctrl.use_rs1  = 1'b1;
			end
			`OP_REG: begin
				bundle.reg_we = 1'b1;
				bundle.alu_op = {funct7_5, funct3};   // ADD/SUB, SRL/SRA split
				ctrl.use_rs1  = 1'b1;
				ctrl.use_rs2  = 1'b1;
			end
			`OP_BRANCH: begin
				bundle.imm   = imm_b;
				ctrl.use_rs1 = 1'b1;
				ctrl.use_rs2 = 1'b1;
				case (funct3)
					3'b000:  bundle.alu_op = `ALU_EQ;
					3'b001:  bundle.alu_op = `ALU_NEQ;
					3'b100:  bundle.alu_op = `ALU_LT;
					3'b101:  bundle.alu_op = `ALU_GE;
					3'b110:  bundle.alu_op = `ALU_LTU;
					3'b111:  bundle.alu_op = `ALU_GEU;
					default: bundle.alu_op = `ALU_ADD;
				endcase
			end
			`OP_LOAD: begin
				bundle.imm    = imm_i;
				bundle.src2   = imm_i;   // Address = rs1 + imm
				bundle.reg_we = 1'b1;
				ctrl.use_rs1  = 1'b1;
				case (funct3)
					3'b000:  bundle.mem_rd = `LD_B;
					3'b001:  bundle.mem_rd = `LD_H;
					3'b010:  bundle.mem_rd = `LD_W;
					3'b100:  bundle.mem_rd = `LD_BU;
					3'b101:  bundle.mem_rd = `LD_HU;
					default: bundle.mem_rd = `LD_NONE;
				endcase
			end
			`OP_STORE: begin
				bundle.imm   = imm_s;
				bundle.src2  = imm_s;
				ctrl.use_rs1 = 1'b1;
				ctrl.use_rs2 = 1'b1;   // Store data
				case (funct3)
					3'b000:  bundle.mem_wr = `ST_B;
					3'b001:  bundle.mem_wr = `ST_H;
					3'b010:  bundle.mem_wr = `ST_W;
					default: bundle.mem_wr = `ST_NONE;
				endcase
			end
			`OP_JAL: begin
				bundle.imm     = imm_j;
				bundle.src1    = pc;
				bundle.src2    = imm_j;
				bundle.reg_we  = 1'b1;
				bundle.is_jump = 1'b1;
				bundle.is_jalr = 1'b1;   // Target computed by the ALU
			end
			`OP_JALR: begin
				bundle.imm     = imm_i;
				bundle.src2    = imm_i;
				bundle.reg_we  = 1'b1;
				bundle.is_jump = 1'b1;
				bundle.is_jalr = 1'b1;
				ctrl.use_rs1   = 1'b1;
			end
			`OP_LUI: begin
				bundle.imm    = imm_u;
				bundle.src1   = '0;
				bundle.src2   = imm_u;
				bundle.reg_we = 1'b1;
			end
			`OP_AUIPC: begin
				bundle.imm    = imm_u;
				bundle.src1   = pc;
				bundle.src2   = imm_u;
				bundle.reg_we = 1'b1;
			end
			`OP_FENCE: begin
				bundle.imm     = 32'd4;   // Refetch at pc + 4
				bundle.fence_i = 1'b1;
			end
			`OP_SYSTEM: begin
				bundle.imm = imm_i;
				case (funct3)
					`F3_PRIV: begin
						if (sys_imm == `IMM_EBREAK) begin
							bundle.ebreak = 1'b1;
						end else if (sys_imm == `IMM_ECALL) begin
							bundle.ecall   = 1'b1;
							bundle.csr_we  = 1'b1;   // Saves pc into mepc
							bundle.is_jalr = 1'b1;
							bundle.src1    = csr_val;
							bundle.src2    = '0;
							ctrl.use_csr   = 1'b1;
						end else if (sys_imm == `IMM_MRET) begin
							bundle.mret = 1'b1;
							bundle.src1 = csr_val;
							bundle.src2 = '0;
							ctrl.use_csr = 1'b1;
						end
					end
					`F3_CSRRW: begin
						bundle.csr_we = 1'b1;
						bundle.src2   = '0;   // CSR gets rs1 + 0
						ctrl.use_rs1  = 1'b1;
					end
					`F3_CSRRS: begin
						bundle.reg_we = 1'b1;
						bundle.src2   = csr_val;
						bundle.alu_op = `ALU_OR;
						ctrl.use_rs1  = 1'b1;
						ctrl.use_csr  = 1'b1;
					end
					default: bundle.alu_op = `ALU_ADD;
				endcase
			end
			default: bundle.imm = '0;
		endcase

		ctrl.csr_rd = bundle.csr_rd;
	end

endmodule

/* verilog/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import core_pkg::*; (
	input  dec_ctrl_t  ctrl,
	input  pipe_dest_t exu_dest,
	input  pipe_dest_t lsu_dest,
	input  pipe_dest_t wbu_dest,
	input  fwd_t       exu_fwd,
	input  fwd_t       lsu_fwd,
	input  fwd_t       wbu_fwd,
	input  xlen_t      rs1_reg,
	input  xlen_t      rs2_reg,
	output xlen_t      rs1_val,
	output xlen_t      rs2_val,
	output logic       stall
);

	pipe_dest_t [2:0] dest;
	fwd_t       [2:0] fwd;
	logic       [2:0] hit1;   // Bit 0 is EXU, bit 2 is WBU
	logic       [2:0] hit2;
	logic       [2:0] csr_hit;
	logic       [2:0] ready;

	assign dest = {wbu_dest, lsu_dest, exu_dest};
	assign fwd  = {wbu_fwd, lsu_fwd, exu_fwd};

	// -------------------- RAW matching
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			hit1[i]    = dest[i].rd_we && (dest[i].rd == ctrl.rs1) && (|ctrl.rs1);
			hit2[i]    = dest[i].rd_we && (dest[i].rd == ctrl.rs2) && (|ctrl.rs2);
			csr_hit[i] = dest[i].csr_we && (dest[i].csr == ctrl.csr_rd);
			ready[i]   = fwd[i].valid;
		end
	end

	// -------------------- Forwarding muxes
	always_comb begin
		rs1_val = rs1_reg;
		rs2_val = rs2_reg;
		for (int i = 2; i >= 0; i--) begin   // Oldest first, EXU overrides last
			if (hit1[i] && ready[i])
				rs1_val = fwd[i].data;
			if (hit2[i] && ready[i])
				rs2_val = fwd[i].data;
		end
	end

	// CSRs are never forwarded, any pending write stalls
	assign stall = (ctrl.use_rs1 && |(hit1 & ~ready)) ||
	               (ctrl.use_rs2 && |(hit2 & ~ready)) ||
	               (ctrl.use_csr && (|ctrl.csr_rd) && (|csr_hit));

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import core_pkg::*; #(
	parameter int NREGS = 16
) (
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t ra1,
	input  reg_addr_t ra2,
	output xlen_t     rd1,
	output xlen_t     rd2,
	input  wb_write_t w
);

	xlen_t regs [NREGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end else if (w.rd_we && (|w.rd)) begin   // x0 ignores writes
			regs[w.rd] <= w.rd_data;
		end
	end

	assign rd1 = (|ra1) ? regs[ra1] : '0;
	assign rd2 = (|ra2) ? regs[ra2] : '0;

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module csr_file import core_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  csr_idx_t  ridx,
	output xlen_t     rdata,
	input  wb_write_t w
);

	xlen_t mstatus;
	xlen_t mtvec;
	xlen_t mepc;
	xlen_t mcause;

	// -------------------- Write port
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (w.csr_we) begin
			case (w.csr)
				`CSR_MSTATUS: mstatus <= w.csr_data;
				`CSR_MTVEC:   mtvec   <= w.csr_data;
				`CSR_MEPC:    mepc    <= w.csr_data;
				`CSR_MCAUSE:  mcause  <= w.csr_data;
				default:      ;   // Identity CSRs are read-only
			endcase
		end
	end

	// -------------------- Read port
	always_comb begin
		case (ridx)
			`CSR_MSTATUS:   rdata = mstatus;
			`CSR_MTVEC:     rdata = mtvec;
			`CSR_MEPC:      rdata = mepc;
			`CSR_MCAUSE:    rdata = mcause;
			`CSR_MVENDORID: rdata = `MVENDORID_VAL;
			`CSR_MARCHID:   rdata = `MARCHID_VAL;
			default:        rdata = '0;
		endcase
	end

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	// -------------------- From IFU
	input  xlen_t       inst,
	input  xlen_t       pc,
	input  logic        in_valid,
	output logic        in_ready,
	// -------------------- To EXU
	output dec_bundle_t bundle,
	output logic        out_valid,
	input  logic        out_ready,
	// -------------------- Hazard and forwarding
	input  pipe_dest_t  exu_dest,
	input  pipe_dest_t  lsu_dest,
	input  pipe_dest_t  wbu_dest,
	input  fwd_t        exu_fwd,
	input  fwd_t        lsu_fwd,
	input  fwd_t        wbu_fwd,
	// -------------------- Write-back
	input  wb_write_t   wb
);

	dec_ctrl_t ctrl;
	xlen_t     rs1_reg;
	xlen_t     rs2_reg;
	xlen_t     rs1_val;
	xlen_t     rs2_val;
	xlen_t     csr_val;
	logic      stall;

	inst_decoder dec_i (
		.inst    (inst),
		.pc      (pc),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.csr_val (csr_val),
		.ctrl    (ctrl),
		.bundle  (bundle)
	);

	operand_forward fwd_i (
		.ctrl     (ctrl),
		.exu_dest (exu_dest),
		.lsu_dest (lsu_dest),
		.wbu_dest (wbu_dest),
		.exu_fwd  (exu_fwd),
		.lsu_fwd  (lsu_fwd),
		.wbu_fwd  (wbu_fwd),
		.rs1_reg  (rs1_reg),
		.rs2_reg  (rs2_reg),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.stall    (stall)
	);

	reg_file #(
		.NREGS (16)
	) rf_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ra1    (ctrl.rs1),
		.ra2    (ctrl.rs2),
		.rd1    (rs1_reg),
		.rd2    (rs2_reg),
		.w      (wb)
	);

	csr_file csr_i (
		.clk    (clk),
		.arst_n (arst_n),
		.ridx   (ctrl.csr_rd),
		.rdata  (csr_val),
		.w      (wb)
	);

	assign in_ready  = out_ready && !stall;   // Hold IFU while a hazard is open
	assign out_valid = in_valid && out_ready && !stall;

endmodule

/* bench/id_stage_chk.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module id_stage_chk import core_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input xlen_t       inst,
	input xlen_t       pc,
	input logic        in_valid,
	input logic        in_ready,
	input logic        out_valid,
	input logic        out_ready,
	input dec_bundle_t bundle,
	input pipe_dest_t  exu_dest,
	input pipe_dest_t  lsu_dest,
	input pipe_dest_t  wbu_dest,
	input fwd_t        exu_fwd,
	input fwd_t        lsu_fwd,
	input fwd_t        wbu_fwd,
	input wb_write_t   wb
);

	int         err_count = 0;   // Failed checks so far
	xlen_t      regs [16];       // Expected register contents
	xlen_t      csrs [8];        // Expected CSRs by index
	logic [6:0] op;
	logic       ecall_i;
	logic       mret_i;
	logic       csrrw_i;
	logic       csrrs_i;
	logic       use1;
	logic       use2;
	csr_idx_t   cidx;
	xlen_t      v1;
	xlen_t      v2;
	xlen_t      imm_i;
	xlen_t      exp_imm;
	xlen_t      exp_src1;
	xlen_t      exp_src2;
	logic       chk_imm;
	logic       hazard;

	// Nearest stage with final data wins
	function automatic xlen_t operand(input reg_addr_t r);
		if (r == '0)
			return '0;
		if (exu_dest.rd_we && exu_dest.rd == r && exu_fwd.valid)
			return exu_fwd.data;
		if (lsu_dest.rd_we && lsu_dest.rd == r && lsu_fwd.valid)
			return lsu_fwd.data;
		if (wbu_dest.rd_we && wbu_dest.rd == r && wbu_fwd.valid)
			return wbu_fwd.data;
		return regs[r];
	endfunction

	function automatic logic waits_on(input reg_addr_t r);
		return (r != '0) &&
		       ((exu_dest.rd_we && exu_dest.rd == r && !exu_fwd.valid) ||
		        (lsu_dest.rd_we && lsu_dest.rd == r && !lsu_fwd.valid) ||
		        (wbu_dest.rd_we && wbu_dest.rd == r && !wbu_fwd.valid));
	endfunction

	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			for (int i = 0; i < 8; i++)
				csrs[i] <= '0;
			csrs[`CSR_MVENDORID] <= `MVENDORID_VAL;
			csrs[`CSR_MARCHID]   <= `MARCHID_VAL;
		end else begin
			if (wb.rd_we && wb.rd != '0)
				regs[wb.rd] <= wb.rd_data;
			if (wb.csr_we && wb.csr inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE})
				csrs[wb.csr] <= wb.csr_data;
		end
	end

	// --------------------
	always_comb begin
		op      = inst[6:0];
		ecall_i = op == `OP_SYSTEM && inst[14:12] == `F3_PRIV && inst[31:20] == `IMM_ECALL;
		mret_i  = op == `OP_SYSTEM && inst[14:12] == `F3_PRIV && inst[31:20] == `IMM_MRET;
		csrrw_i = op == `OP_SYSTEM && inst[14:12] == `F3_CSRRW;
		csrrs_i = op == `OP_SYSTEM && inst[14:12] == `F3_CSRRS;
		use1    = csrrw_i || csrrs_i ||
		          op inside {`OP_IMM, `OP_REG, `OP_BRANCH, `OP_LOAD, `OP_STORE, `OP_JALR};
		use2    = op inside {`OP_REG, `OP_BRANCH, `OP_STORE};
		cidx    = `CSR_NONE;
		if (ecall_i)
			cidx = `CSR_MTVEC;
		else if (mret_i)
			cidx = `CSR_MEPC;
		else if (csrrs_i) begin
			case (inst[31:20])
				`CSR_ADDR_MSTATUS:   cidx = `CSR_MSTATUS;
				`CSR_ADDR_MTVEC:     cidx = `CSR_MTVEC;
				`CSR_ADDR_MEPC:      cidx = `CSR_MEPC;
				`CSR_ADDR_MCAUSE:    cidx = `CSR_MCAUSE;
				`CSR_ADDR_MVENDORID: cidx = `CSR_MVENDORID;
				`CSR_ADDR_MARCHID:   cidx = `CSR_MARCHID;
				default:             cidx = `CSR_NONE;
			endcase
		end
		v1     = operand(inst[18:15]);
		v2     = operand(inst[23:20]);
		hazard = (use1 && waits_on(inst[18:15])) || (use2 && waits_on(inst[23:20])) ||
		         (cidx != `CSR_NONE &&
		          ((exu_dest.csr_we && exu_dest.csr == cidx) ||
		           (lsu_dest.csr_we && lsu_dest.csr == cidx) ||
		           (wbu_dest.csr_we && wbu_dest.csr == cidx)));

		imm_i    = xlen_t'($signed(inst) >>> 20);
		chk_imm  = 1'b1;
		exp_imm  = imm_i;
		exp_src1 = v1;
		exp_src2 = v2;
		case (op)
			`OP_IMM, `OP_LOAD, `OP_JALR:
				exp_src2 = imm_i;
			`OP_STORE: begin
				exp_imm  = {imm_i[31:5], inst[11:7]};
				exp_src2 = exp_imm;
			end
			`OP_BRANCH:
				exp_imm = {imm_i[31:12], inst[7], inst[30:25], inst[11:8], 1'b0};
			`OP_JAL: begin
				exp_imm  = xlen_t'($signed({inst[31], inst[19:12], inst[20], inst[30:21],
				                            12'b0}) >>> 11);
				exp_src1 = pc;
				exp_src2 = exp_imm;
			end
			`OP_LUI, `OP_AUIPC: begin
				exp_imm  = {inst[31:12], 12'h000};
				exp_src1 = (op == `OP_LUI) ? '0 : pc;
				exp_src2 = exp_imm;
			end
			`OP_SYSTEM: begin
				if (ecall_i || mret_i) begin
					exp_src1 = csrs[cidx];   // Trap or return target
					exp_src2 = '0;
				end else if (csrrw_i) begin
					exp_src2 = '0;
				end else if (csrrs_i) begin
					exp_src2 = csrs[cidx];
				end
			end
			default:
				chk_imm = 1'b0;   // R-type carries no immediate
		endcase
	end

	// -------------------- Assertions
	a_imm: assert property (@(posedge clk) disable iff (!arst_n)
		chk_imm |-> bundle.imm == exp_imm)
	else begin
		err_count++;
		$error("FAIL %0t bundle.imm got %h exp %h", $time, $sampled(bundle.imm),
		       $sampled(exp_imm));
	end

	a_src1: assert property (@(posedge clk) disable iff (!arst_n)
		!hazard |-> bundle.src1 == exp_src1)
	else begin
		err_count++;
		$error("FAIL %0t bundle.src1 got %h exp %h", $time, $sampled(bundle.src1),
		       $sampled(exp_src1));
	end

	a_src2: assert property (@(posedge clk) disable iff (!arst_n)
		!hazard |-> bundle.src2 == exp_src2)
	else begin
		err_count++;
		$error("FAIL %0t bundle.src2 got %h exp %h", $time, $sampled(bundle.src2),
		       $sampled(exp_src2));
	end

	a_store: assert property (@(posedge clk) disable iff (!arst_n)
		(!hazard && op == `OP_STORE) |-> bundle.store_data == v2)
	else begin
		err_count++;
		$error("FAIL %0t bundle.store_data got %h exp %h", $time,
		       $sampled(bundle.store_data), $sampled(v2));
	end

	a_stall: assert property (@(posedge clk) disable iff (!arst_n)
		hazard |-> !in_ready && !out_valid)
	else begin
		err_count++;
		$error("FAIL %0t in_ready/out_valid got %b/%b exp 0/0", $time,
		       $sampled(in_ready), $sampled(out_valid));
	end

	a_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
		(!hazard && out_ready) |-> in_ready)
	else begin
		err_count++;
		$error("FAIL %0t in_ready got %b exp 1", $time, $sampled(in_ready));
	end

	a_valid: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == (in_valid && in_ready))
	else begin
		err_count++;
		$error("FAIL %0t out_valid got %b exp %b", $time, $sampled(out_valid),
		       $sampled(in_valid && in_ready));
	end

	a_backpressure: assert property (@(posedge clk) disable iff (!arst_n)
		!out_ready |-> !in_ready)
	else begin
		err_count++;
		$error("FAIL %0t in_ready got %b exp 0", $time, $sampled(in_ready));
	end

endmodule

/* bench/tb_id_stage.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_id_stage import core_pkg::*; ();

	localparam int PHASE_LEN  = 60;
	localparam int MAX_CYCLES = 2 + 5 * PHASE_LEN + 98;   // Reset, five phases, slack

	logic        clk;
	logic        arst_n;
	xlen_t       inst;
	xlen_t       pc;
	logic        in_valid;
	logic        in_ready;
	dec_bundle_t bundle;
	logic        out_valid;
	logic        out_ready;
	pipe_dest_t  exu_dest;
	pipe_dest_t  lsu_dest;
	pipe_dest_t  wbu_dest;
	fwd_t        exu_fwd;
	fwd_t        lsu_fwd;
	fwd_t        wbu_fwd;
	wb_write_t   wb;
	logic [31:0] seed = 32'he1a44ac5;
	int          cycles = 0;

	id_stage dut_i (.*);

	bind id_stage id_stage_chk chk_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Some tests failed");
			$fatal(1, "Timeout after %0d cycles", cycles);
		end
	end

	initial begin
		wait (dut_i.chk_i.err_count != 0);
		$display("Some tests failed");
		$fatal(1, "Assertion failure in id_stage_chk");
	end

	// -------------------- Stimulus helpers
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [11:0] csr_number(input logic [2:0] sel);
		case (sel)
			3'd0:    return `CSR_ADDR_MSTATUS;
			3'd1:    return `CSR_ADDR_MTVEC;
			3'd2:    return `CSR_ADDR_MEPC;
			3'd3:    return `CSR_ADDR_MCAUSE;
			3'd4:    return `CSR_ADDR_MVENDORID;
			default: return `CSR_ADDR_MARCHID;
		endcase
	endfunction

	function automatic xlen_t encode_inst(input int kind, input logic [31:0] r);
		xlen_t      base;
		logic [6:0] op;
		logic [2:0] f3;
		base = r & 32'hfef7_f780;   // Opcode and register bit 4 cleared
		f3   = r[14:12];
		case (kind)
			0: begin
				op = `OP_IMM;
				f3 = {r[13], 2'b00};
			end
			1: begin
				op          = `OP_REG;
				f3          = {r[13], 2'b00};
				base[31:25] = '0;
			end
			2: begin
				op = `OP_BRANCH;
				if (f3[2:1] == 2'b01)
					f3 = 3'b000;
			end
			3: begin
				op = `OP_LOAD;
				f3 = 3'b010;
			end
			4: begin
				op = `OP_STORE;
				f3 = 3'b010;
			end
			5: op = `OP_JAL;
			6: begin
				op = `OP_JALR;
				f3 = 3'b000;
			end
			7: op = `OP_LUI;
			8: op = `OP_AUIPC;
			9, 10: begin
				op          = `OP_SYSTEM;
				f3          = (kind == 9) ? `F3_CSRRS : `F3_CSRRW;
				base[31:20] = csr_number(r[2:0]);
			end
			11: return {`IMM_ECALL, 13'b0, `OP_SYSTEM};
			default: return {`IMM_MRET, 13'b0, `OP_SYSTEM};
		endcase
		return {base[31:15], f3, base[11:7], op};
	endfunction

	// Pending writer aimed at one of the sources of ins
	function automatic pipe_dest_t aim_dest(input xlen_t ins, input logic [31:0] r);
		pipe_dest_t d;
		d.rd     = r[0] ? ins[18:15] : ins[23:20];
		d.rd_we  = r[1];
		d.csr    = csr_idx_t'(r[3:2]) + 3'd1;   // Writable CSRs only
		d.csr_we = r[4] & r[5];
		return d;
	endfunction

	function automatic fwd_t rand_fwd(input logic [31:0] r);
		fwd_t f;
		f.data  = next_rand();
		f.valid = r[6] | r[7];
		return f;
	endfunction

	// -------------------- Phases
	task automatic drive_phase(input int phase);
		logic [31:0] r;
		logic [31:0] r2;
		int          kind;
		for (int n = 0; n < PHASE_LEN; n++) begin
			@(negedge clk);
			r         = next_rand();
			r2        = next_rand();
			kind      = (phase == 4) ? 9 + int'(r[4:3]) : int'(r[11:8]) % 13;
			in_valid  = r[0] | r[1];
			out_ready = (phase == 5) ? r[2] : 1'b1;
			pc        = r2 & ~32'h3;
			inst      = encode_inst(kind, next_rand());
			wb.rd       = r[15:12];
			wb.rd_we    = (phase == 1) || r[16];
			wb.rd_data  = next_rand();
			wb.csr      = r[19:17];
			wb.csr_we   = (phase == 4) || (phase == 5 && r[20]);
			wb.csr_data = next_rand();
			if (phase >= 3) begin
				exu_dest = aim_dest(inst, next_rand());
				lsu_dest = aim_dest(inst, next_rand());
				wbu_dest = aim_dest(inst, next_rand());
				exu_fwd  = rand_fwd(next_rand());
				lsu_fwd  = rand_fwd(next_rand());
				wbu_fwd  = rand_fwd(next_rand());
			end
		end
	endtask

	initial begin
		arst_n    = 1'b0;
		inst      = '0;
		pc        = '0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		exu_dest  = '0;
		lsu_dest  = '0;
		wbu_dest  = '0;
		exu_fwd   = '0;
		lsu_fwd   = '0;
		wbu_fwd   = '0;
		wb        = '0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		for (int p = 1; p <= 5; p++)
			drive_phase(p);
		@(negedge clk);
		if (dut_i.chk_i.err_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "Assertion failures recorded");
		end
	end

endmodule

/* tb.f */
+incdir+include
verilog/core_pkg.sv
verilog/inst_decoder.sv
verilog/operand_forward.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/id_stage.sv
bench/id_stage_chk.sv
bench/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/core_pkg.sv
      - verilog/inst_decoder.sv
      - verilog/operand_forward.sv
      - verilog/reg_file.sv
      - verilog/csr_file.sv
      - verilog/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/id_stage_chk.sv
      - bench/tb_id_stage.sv
